/* logic/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Instruction word layout
`define INSTR_WIDTH     32
`define OPCODE_WIDTH    6
`define REG_ADDR_WIDTH  5

// Opcode field, bits 31:26
`define OP_RTYPE  6'b000000     // Selects on funct
`define OP_ADDI   6'b001000
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_LW     6'b100011
`define OP_SW     6'b101011
`define OP_J      6'b000010

// Branch opcodes, some borrowed from unused MIPS load slots
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLT    6'b110000
`define OP_BGT    6'b001111
`define OP_BLE    6'b100101
`define OP_BGE    6'b100100

// Funct field, bits 5:0, under OP_RTYPE
`define FUNCT_ADD 6'b100000
`define FUNCT_SUB 6'b100010
`define FUNCT_AND 6'b100100
`define FUNCT_OR  6'b100101
`define FUNCT_XOR 6'b100110
`define FUNCT_NOR 6'b100111
`define FUNCT_SLL 6'b000000
`define FUNCT_SRL 6'b000010

`endif

/* logic/decode_pkg.sv */
package decode_pkg;

`include "decode_config.svh"

    // R-type view of the instruction word
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] shamt;     // Unused by the decoder, ALU takes it directly
        logic [5:0]                 funct;
    } r_fields_t;

    // I-type view; imm fills whatever is left after opcode, rs and rt
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`INSTR_WIDTH-`OPCODE_WIDTH-2*`REG_ADDR_WIDTH-1:0] imm;
    } i_fields_t;

    // One word, read through either view depending on the opcode
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_NONE = 4'b0000,
        ALU_ADD  = 4'b0010,
        ALU_SUB  = 4'b0011,
        ALU_AND  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_SLL  = 4'b1000,
        ALU_SRL  = 4'b1001,
        ALU_NOR  = 4'b1010
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GT   = 3'd4,
        BR_LE   = 3'd5,
        BR_GE   = 3'd6
    } branch_cond_t;

    typedef struct packed {
        alu_op_t                    alu_op;
        logic                       alu_src;            // 1 selects the immediate as operand B
        logic                       reg_write_enable;
        logic                       mem_to_reg;         // Write-back from RAM instead of ALU
        logic [`REG_ADDR_WIDTH-1:0] read_register_1;
        logic [`REG_ADDR_WIDTH-1:0] read_register_2;
        logic [`REG_ADDR_WIDTH-1:0] write_register;
        logic                       pc_increment;
        logic                       ram_read_enable;
        logic                       ram_write_enable;
        logic                       jump;
        branch_cond_t               branch;
    } ctrl_word_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    is_shift;     // sll/srl take rt as the shifted operand
        logic    known;        // Funct code is one we decode
    } funct_ctrl_t;

endpackage

/* logic/funct_decode.sv */
`timescale 1ns/100ps

`include "decode_config.svh"

module funct_decode (
    input  logic [5:0]              funct,
    output decode_pkg::funct_ctrl_t fctrl
);

    always_comb
    begin
        fctrl.alu_op   = decode_pkg::ALU_NONE;   // Unknown codes fall through as zero
        fctrl.is_shift = 1'b0;
        fctrl.known    = 1'b1;
        case (funct)
            `FUNCT_ADD:
            begin
                fctrl.alu_op = decode_pkg::ALU_ADD;
            end
            `FUNCT_SUB:
            begin
                fctrl.alu_op = decode_pkg::ALU_SUB;
            end
            `FUNCT_AND:
            begin
                fctrl.alu_op = decode_pkg::ALU_AND;
            end
            `FUNCT_OR:
            begin
                fctrl.alu_op = decode_pkg::ALU_OR;
            end
            `FUNCT_XOR:
            begin
                fctrl.alu_op = decode_pkg::ALU_XOR;
            end
            `FUNCT_NOR:
            begin
                fctrl.alu_op = decode_pkg::ALU_NOR;
            end
            `FUNCT_SLL:
            begin
                fctrl.alu_op   = decode_pkg::ALU_SLL;
                fctrl.is_shift = 1'b1;
            end
            `FUNCT_SRL:
            begin
                fctrl.alu_op   = decode_pkg::ALU_SRL;
                fctrl.is_shift = 1'b1;
            end
            default:
            begin
                fctrl.known = 1'b0;          // Caller turns this into a skip
            end
        endcase
    end

endmodule

/* logic/opcode_decode.sv */
`timescale 1ns/100ps

`include "decode_config.svh"

module opcode_decode (
    input  decode_pkg::instr_t     instruction,
    output decode_pkg::ctrl_word_t ctrl_next
);

    decode_pkg::funct_ctrl_t  fctrl;
    decode_pkg::branch_cond_t branch_cond;

    funct_decode u_funct_decode (
        .funct (instruction.r.funct),
        .fctrl (fctrl)
    );

    // Branch opcodes map straight onto a condition; everything else is BR_NONE
    always_comb
    begin
        case (instruction.i.opcode)
            `OP_BEQ: branch_cond = decode_pkg::BR_EQ;
            `OP_BNE: branch_cond = decode_pkg::BR_NE;
            `OP_BLT: branch_cond = decode_pkg::BR_LT;
            `OP_BGT: branch_cond = decode_pkg::BR_GT;
            `OP_BLE: branch_cond = decode_pkg::BR_LE;
            `OP_BGE: branch_cond = decode_pkg::BR_GE;
            default: branch_cond = decode_pkg::BR_NONE;
        endcase
    end

    always_comb
    begin
        // Start from the skip word; each case only raises what it needs
        ctrl_next              = '0;
        ctrl_next.pc_increment = 1'b1;

        case (instruction.i.opcode)
            `OP_RTYPE:
            begin
                if (fctrl.known)
                begin
                    ctrl_next.alu_op           = fctrl.alu_op;
                    ctrl_next.reg_write_enable = 1'b1;
                    ctrl_next.write_register   = instruction.r.rd;
                    if (fctrl.is_shift)
                    begin
                        ctrl_next.read_register_1 = instruction.r.rt;   // Shift amount comes from shamt
                    end
                    else
                    begin
                        ctrl_next.read_register_1 = instruction.r.rs;
                        ctrl_next.read_register_2 = instruction.r.rt;
                    end
                end
            end
            `OP_ADDI, `OP_ANDI, `OP_ORI:
            begin
                case (instruction.i.opcode)
                    `OP_ANDI: ctrl_next.alu_op = decode_pkg::ALU_AND;
                    `OP_ORI:  ctrl_next.alu_op = decode_pkg::ALU_OR;
                    default:  ctrl_next.alu_op = decode_pkg::ALU_ADD;
                endcase
                ctrl_next.alu_src          = 1'b1;
                ctrl_next.reg_write_enable = 1'b1;
                ctrl_next.read_register_1  = instruction.i.rs;
                ctrl_next.write_register   = instruction.i.rt;
            end
            `OP_LW:
            begin
                ctrl_next.alu_op           = decode_pkg::ALU_ADD;   // Base plus offset
                ctrl_next.alu_src          = 1'b1;
                ctrl_next.reg_write_enable = 1'b1;
                ctrl_next.mem_to_reg       = 1'b1;
                ctrl_next.ram_read_enable  = 1'b1;
                ctrl_next.read_register_1  = instruction.i.rs;
                ctrl_next.write_register   = instruction.i.rt;
            end
            `OP_SW:
            begin
                ctrl_next.alu_op           = decode_pkg::ALU_ADD;
                ctrl_next.alu_src          = 1'b1;
                ctrl_next.ram_write_enable = 1'b1;
                ctrl_next.read_register_1  = instruction.i.rs;
                ctrl_next.read_register_2  = instruction.i.rt;  // Store data
            end
            `OP_J:
            begin
                ctrl_next.jump = 1'b1;
            end
            default:
            begin
                if (branch_cond != decode_pkg::BR_NONE)
                begin
                    ctrl_next.alu_op          = decode_pkg::ALU_SUB;    // Compare by subtraction
                    ctrl_next.read_register_1 = instruction.i.rs;
                    ctrl_next.read_register_2 = instruction.i.rt;
                    ctrl_next.branch          = branch_cond;
                end
            end
        endcase
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  decode_pkg::instr_t     instruction,
    output decode_pkg::ctrl_word_t ctrl
);

    decode_pkg::ctrl_word_t ctrl_next;

    opcode_decode u_opcode_decode (
        .instruction (instruction),
        .ctrl_next   (ctrl_next)
    );

    // One cycle from instruction to control word, new word every clock
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl <= '0;             // All enables low, branch is BR_NONE
        end
        else
        begin
            ctrl <= ctrl_next;
        end
    end

endmodule

/* testbench/control_unit_assert.sv */
`timescale 1ns/100ps

module control_unit_assert (
    input logic                   clk,
    input logic                   reset,
    input decode_pkg::ctrl_word_t ctrl
);

    // RAM port is single ported, one direction per cycle
    ram_one_direction: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.ram_read_enable && ctrl.ram_write_enable))
        else $error("RAM read and write enables are high together");

    load_writes_back: assert property (@(posedge clk) disable iff (reset)
        ctrl.mem_to_reg |-> ctrl.reg_write_enable)
        else $error("mem_to_reg set without reg_write_enable");

    // Control transfers never touch the register file
    flow_no_write: assert property (@(posedge clk) disable iff (reset)
        (ctrl.jump || ctrl.branch != decode_pkg::BR_NONE) |-> !ctrl.reg_write_enable)
        else $error("Branch or jump word has reg_write_enable set");

endmodule

/* testbench/control_checker.sv */
`timescale 1ns/100ps

`include "decode_config.svh"

module control_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [2:0]             test_group,
    input  decode_pkg::instr_t     instruction,
    input  decode_pkg::ctrl_word_t ctrl,
    output int                     checks_passed,
    output int                     checks_failed
);

    decode_pkg::instr_t     pending_instr;
    decode_pkg::ctrl_word_t pending_exp;
    logic [2:0]             pending_group;
    logic                   pending_valid = 1'b0;
    logic [2:0]             report_group  = 3'd0;    // Group whose results are being collected
    int                     group_checks  = 0;
    int                     group_errors  = 0;
    int                     passed_count  = 0;
    int                     failed_count  = 0;
    string                  names [6] = '{"idle", "reset", "r_and_i_type",
                                          "memory_branch_jump", "unrecognized", "random_words"};

    assign checks_passed = passed_count;
    assign checks_failed = failed_count;

    function automatic decode_pkg::alu_op_t funct_alu_op(input logic [5:0] fn);
        case (fn)
            `FUNCT_ADD: return decode_pkg::ALU_ADD;
            `FUNCT_SUB: return decode_pkg::ALU_SUB;
            `FUNCT_AND: return decode_pkg::ALU_AND;
            `FUNCT_OR:  return decode_pkg::ALU_OR;
            `FUNCT_XOR: return decode_pkg::ALU_XOR;
            `FUNCT_NOR: return decode_pkg::ALU_NOR;
            `FUNCT_SLL: return decode_pkg::ALU_SLL;
            `FUNCT_SRL: return decode_pkg::ALU_SRL;
            default:    return decode_pkg::ALU_NONE;    // Dropped or unknown funct
        endcase
    endfunction

    function automatic decode_pkg::branch_cond_t opcode_branch(input logic [5:0] op);
        case (op)
            `OP_BEQ: return decode_pkg::BR_EQ;
            `OP_BNE: return decode_pkg::BR_NE;
            `OP_BLT: return decode_pkg::BR_LT;
            `OP_BGT: return decode_pkg::BR_GT;
            `OP_BLE: return decode_pkg::BR_LE;
            `OP_BGE: return decode_pkg::BR_GE;
            default: return decode_pkg::BR_NONE;
        endcase
    endfunction

    function automatic decode_pkg::ctrl_word_t expected_ctrl(input decode_pkg::instr_t instr);
        decode_pkg::ctrl_word_t e;
        logic [5:0]             op;
        logic                   shift;
        op             = instr.i.opcode;
        e              = '0;
        e.pc_increment = 1'b1;                // Skip word unless a rule below applies
        e.branch       = opcode_branch(op);
        if (e.branch != decode_pkg::BR_NONE)
        begin
            e.alu_op          = decode_pkg::ALU_SUB;
            e.read_register_1 = instr.i.rs;
            e.read_register_2 = instr.i.rt;
        end
        else if (op == `OP_J)
            e.jump = 1'b1;
        else if (op == `OP_RTYPE && funct_alu_op(instr.r.funct) != decode_pkg::ALU_NONE)
        begin
            e.alu_op           = funct_alu_op(instr.r.funct);
            shift = (e.alu_op == decode_pkg::ALU_SLL) || (e.alu_op == decode_pkg::ALU_SRL);
            e.reg_write_enable = 1'b1;
            e.write_register   = instr.r.rd;
            e.read_register_1  = shift ? instr.r.rt : instr.r.rs;
            e.read_register_2  = shift ? 5'd0 : instr.r.rt;
        end
        else if (op == `OP_ADDI || op == `OP_ANDI || op == `OP_ORI || op == `OP_LW || op == `OP_SW)
        begin
            e.alu_op          = decode_pkg::ALU_ADD;  // Address add for lw and sw too
            e.alu_src         = 1'b1;
            e.read_register_1 = instr.i.rs;
            if (op == `OP_ANDI)
                e.alu_op = decode_pkg::ALU_AND;
            if (op == `OP_ORI)
                e.alu_op = decode_pkg::ALU_OR;
            if (op == `OP_SW)
            begin
                e.read_register_2  = instr.i.rt;
                e.ram_write_enable = 1'b1;
            end
            else
            begin
                e.reg_write_enable = 1'b1;
                e.write_register   = instr.i.rt;
            end
            e.mem_to_reg      = (op == `OP_LW);
            e.ram_read_enable = (op == `OP_LW);
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [4:0] exp_v,
                               input logic [4:0] act_v, inout logic ok);
        if (exp_v !== act_v)
        begin
            $display("FAILED ctrl.%s expected 0x%0h actual 0x%0h, instruction 0x%08h",
                     name, exp_v, act_v, pending_instr);
            ok = 1'b0;
        end
    endtask

    task automatic compare_word(input decode_pkg::ctrl_word_t e, input decode_pkg::ctrl_word_t a);
        logic ok;
        ok = 1'b1;
        check_field("alu_op", {1'b0, e.alu_op}, {1'b0, a.alu_op}, ok);
        check_field("alu_src", {4'b0, e.alu_src}, {4'b0, a.alu_src}, ok);
        check_field("reg_write_enable", {4'b0, e.reg_write_enable}, {4'b0, a.reg_write_enable}, ok);
        check_field("mem_to_reg", {4'b0, e.mem_to_reg}, {4'b0, a.mem_to_reg}, ok);
        check_field("read_register_1", e.read_register_1, a.read_register_1, ok);
        check_field("read_register_2", e.read_register_2, a.read_register_2, ok);
        check_field("write_register", e.write_register, a.write_register, ok);
        check_field("pc_increment", {4'b0, e.pc_increment}, {4'b0, a.pc_increment}, ok);
        check_field("ram_read_enable", {4'b0, e.ram_read_enable}, {4'b0, a.ram_read_enable}, ok);
        check_field("ram_write_enable", {4'b0, e.ram_write_enable}, {4'b0, a.ram_write_enable}, ok);
        check_field("jump", {4'b0, e.jump}, {4'b0, a.jump}, ok);
        check_field("branch", {2'b0, e.branch}, {2'b0, a.branch}, ok);
        group_checks = group_checks + 1;
        if (ok)
            passed_count = passed_count + 1;
        else
        begin
            failed_count = failed_count + 1;
            group_errors = group_errors + 1;
        end
    endtask

    // ctrl seen at this edge belongs to the word sampled at the previous edge
    always @(posedge clk)
    begin
        if (pending_valid && pending_group != report_group)
        begin
            if (report_group != 3'd0)
                $display("Test %s: %0d words checked, %0d with errors",
                         names[report_group], group_checks, group_errors);
            report_group = pending_group;
            group_checks = 0;
            group_errors = 0;
        end
        if (pending_valid && pending_group != 3'd0)
            compare_word(pending_exp, ctrl);
        pending_instr = instruction;
        pending_group = test_group;
        pending_valid = 1'b1;
        if (reset)
            pending_exp = '0;
        else
            pending_exp = expected_ctrl(instruction);
    end

endmodule

/* testbench/control_unit_tb.sv */
`timescale 1ns/100ps

`include "decode_config.svh"

module control_unit_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_WORDS   = 400;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int KEPT_KINDS     = 20;     // Leading entries of the directed list

    logic                   clk;
    logic                   reset;
    decode_pkg::instr_t     instruction;
    decode_pkg::ctrl_word_t ctrl;
    logic [2:0]             test_group;     // Tag travels with each word to the checker
    int                     checks_passed;
    int                     checks_failed;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;
    int                     sel;
    integer                 seed = 32'h7540_0e28;
    logic [31:0]            rnd;
    logic [31:0]            base;
    logic [31:0]            directed_words[$];
    logic [2:0]             directed_groups[$];

    control_unit DUT (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    control_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .test_group    (test_group),
        .instruction   (instruction),
        .ctrl          (ctrl),
        .checks_passed (checks_passed),
        .checks_failed (checks_failed)
    );

    bind control_unit control_unit_assert u_assert (.clk(clk), .reset(reset), .ctrl(ctrl));

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_word(input logic [31:0] w, input logic [2:0] g);
        directed_words.push_back(w);
        directed_groups.push_back(g);
    endtask

    task automatic drive_word(input logic [31:0] w, input logic [2:0] g);
        instruction <= w;
        test_group  <= g;
        @(posedge clk);
    endtask

    initial
    begin
        reset       = 1'b1;
        instruction = {`OP_LW, 5'd4, 5'd5, 16'h0010};   // Live word, reset has to mask it
        test_group  = 3'd1;
        add_word({`OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, `FUNCT_ADD}, 3'd2);
        add_word({`OP_RTYPE, 5'd4, 5'd5, 5'd6, 5'd0, `FUNCT_SUB}, 3'd2);
        add_word({`OP_RTYPE, 5'd7, 5'd8, 5'd9, 5'd0, `FUNCT_AND}, 3'd2);
        add_word({`OP_RTYPE, 5'd10, 5'd11, 5'd12, 5'd0, `FUNCT_OR}, 3'd2);
        add_word({`OP_RTYPE, 5'd13, 5'd14, 5'd15, 5'd0, `FUNCT_XOR}, 3'd2);
        add_word({`OP_RTYPE, 5'd16, 5'd17, 5'd18, 5'd0, `FUNCT_NOR}, 3'd2);
        add_word({`OP_RTYPE, 5'd19, 5'd20, 5'd21, 5'd3, `FUNCT_SLL}, 3'd2);   // rs nonzero on purpose
        add_word({`OP_RTYPE, 5'd22, 5'd23, 5'd24, 5'd7, `FUNCT_SRL}, 3'd2);
        add_word({`OP_ADDI, 5'd25, 5'd26, 16'h8001}, 3'd2);
        add_word({`OP_ANDI, 5'd27, 5'd28, 16'h00ff}, 3'd2);
        add_word({`OP_ORI, 5'd29, 5'd30, 16'hf0f0}, 3'd2);
        add_word({`OP_LW, 5'd31, 5'd1, 16'h0004}, 3'd3);
        add_word({`OP_SW, 5'd2, 5'd3, 16'hfffc}, 3'd3);
        add_word({`OP_BEQ, 5'd4, 5'd5, 16'h0010}, 3'd3);
        add_word({`OP_BNE, 5'd6, 5'd7, 16'h0020}, 3'd3);
        add_word({`OP_BLT, 5'd8, 5'd9, 16'h0030}, 3'd3);
        add_word({`OP_BGT, 5'd10, 5'd11, 16'h0040}, 3'd3);
        add_word({`OP_BLE, 5'd12, 5'd13, 16'h0050}, 3'd3);
        add_word({`OP_BGE, 5'd14, 5'd15, 16'h0060}, 3'd3);
        add_word({`OP_J, 26'h3ff_ffff}, 3'd3);
        add_word({6'b000001, 5'd1, 5'd2, 16'h1234}, 3'd4);
        add_word({6'b000011, 26'h000_0100}, 3'd4);                       // jal
        add_word({6'b010000, 5'd3, 5'd4, 16'h5678}, 3'd4);
        add_word({6'b111111, 26'h3ff_ffff}, 3'd4);
        add_word({`OP_RTYPE, 5'd31, 5'd0, 5'd0, 5'd0, 6'b001000}, 3'd4);    // jr
        add_word({`OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, 6'b100001}, 3'd4);     // addu
        add_word({`OP_RTYPE, 5'd4, 5'd5, 5'd6, 5'd0, 6'b100011}, 3'd4);     // subu
        add_word({`OP_RTYPE, 5'd7, 5'd8, 5'd9, 5'd0, 6'b101010}, 3'd4);     // slt
        cycle_limit = RESET_CYCLES + directed_words.size() + RANDOM_WORDS + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        foreach (directed_words[k])
            drive_word(directed_words[k], directed_groups[k]);
        for (int i = 0; i < RANDOM_WORDS; i++)
        begin
            rnd = $random(seed);
            if (i % 2 == 0)
            begin
                sel        = $unsigned($random(seed)) % KEPT_KINDS;
                base       = directed_words[sel];
                rnd[31:26] = base[31:26];                // Kept opcode, random fields
                if (base[31:26] == `OP_RTYPE)
                    rnd[5:0] = base[5:0];
            end
            drive_word(rnd, 3'd5);
        end
        repeat (3) drive_word(32'h0, 3'd0);              // Idle tail closes the last group
        $display("Checks: %0d passed, %0d failed", checks_passed, checks_failed);
        if (checks_failed == 0 && checks_passed > 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+logic
logic/decode_pkg.sv
logic/funct_decode.sv
logic/opcode_decode.sv
logic/control_unit.sv
testbench/control_unit_assert.sv
testbench/control_checker.sv
testbench/control_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module control_unit_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcontrol_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
